// File: run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module rv_exec_tb -f verilog.f \
  --Mdir obj_dir -o rv_exec_sim

status=0
./obj_dir/rv_exec_sim +verilator+error+limit+1000 > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log || [ "$status" -ne 0 ]; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"

// File: tests/exec_input.txt
# test instr pc rs1_val rs2_val rd wb_en wb_data next_pc ebreak (test decimal, rest hex)
# rd and wb_data are 0 where wb_en is 0
1 003100b3 00000100 00000005 00000007 01 1 0000000c 00000104 0
2 40310233 00000104 00000010 00000020 04 1 fffffff0 00000108 0
3 407352b3 00000108 f0000000 00000004 05 1 ff000000 0000010c 0
4 00a4b433 0000010c 00000001 ffffffff 08 1 00000001 00000110 0
5 00a4a5b3 00000110 ffffffff 00000001 0b 1 00000001 00000114 0
6 00e6f633 00000114 ff00ff00 0ff00ff0 0c 1 0f000f00 00000118 0
7 fff10093 00000118 00000005 00000000 01 1 00000004 0000011c 0
8 0ff14193 0000011c 0f0f0f0f 00000000 03 1 0f0f0ff0 00000120 0
9 40835293 00000120 80000000 00000000 05 1 ff800000 00000124 0
10 00431393 00000124 12345678 00000000 07 1 23456780 00000128 0
11 12345537 00000128 00000000 00000000 0a 1 12345000 0000012c 0
12 00001597 00000200 00000000 00000000 0b 1 00001200 00000204 0
13 020000ef 00000300 00000000 00000000 01 1 00000304 00000320 0
14 004280e7 00000320 00001001 00000000 01 1 00000324 00001004 0
# Branches with offset 16, taken then not taken
15 00208863 00000400 00000005 00000005 00 0 00000000 00000410 0
16 00208863 00000400 00000005 00000006 00 0 00000000 00000404 0
17 00209863 00000400 00000005 00000006 00 0 00000000 00000410 0
18 00209863 00000400 00000007 00000007 00 0 00000000 00000404 0
19 0020c863 00000400 ffffffff 00000001 00 0 00000000 00000410 0
20 0020c863 00000400 00000001 ffffffff 00 0 00000000 00000404 0
21 0020d863 00000400 00000001 ffffffff 00 0 00000000 00000410 0
22 0020d863 00000400 ffffffff 00000001 00 0 00000000 00000404 0
23 0020e863 00000400 00000001 ffffffff 00 0 00000000 00000410 0
24 0020e863 00000400 ffffffff 00000001 00 0 00000000 00000404 0
25 0020f863 00000400 ffffffff 00000001 00 0 00000000 00000410 0
26 0020f863 00000400 00000001 ffffffff 00 0 00000000 00000404 0
# CSR read-modify-write on mtvec and mepc
27 305110f3 00000500 00000800 00000000 01 1 00000000 00000504 0
28 305221f3 00000504 00000030 00000000 03 1 00000800 00000508 0
29 305332f3 00000508 00000010 00000000 05 1 00000830 0000050c 0
30 305023f3 0000050c 00000000 00000000 07 1 00000820 00000510 0
31 341e5473 00000510 00000000 00000000 08 1 00000000 00000514 0
32 3411e4f3 00000514 00000000 00000000 09 1 0000001c 00000518 0
33 3410f573 00000518 00000000 00000000 0a 1 0000001f 0000051c 0
34 341025f3 0000051c 00000000 00000000 0b 1 0000001e 00000520 0
# Trap entry and return
35 30046073 00000520 00000000 00000000 00 0 00000000 00000524 0
36 00000073 00000600 00000000 00000000 00 0 00000000 00000820 0
37 341020f3 00000820 00000000 00000000 01 1 00000600 00000824 0
38 34202173 00000824 00000000 00000000 02 1 0000000b 00000828 0
39 300021f3 00000828 00000000 00000000 03 1 00000080 0000082c 0
40 30200073 0000082c 00000000 00000000 00 0 00000000 00000600 0
41 30002273 00000600 00000000 00000000 04 1 00000088 00000604 0
42 00100073 00000604 00000000 00000000 00 0 00000000 00000608 1
43 00508013 00000608 00000001 00000000 00 0 00000000 0000060c 0

// File: tests/rv_exec_properties.sv
module rv_exec_props (
  input logic                   clk,
  input logic                   rst,
  input logic                   in_valid_i,
  input logic                   in_ready_o,
  input rv_exec_pkg::exec_in_t  in_data_i,
  input logic                   out_valid_o,
  input logic                   out_ready_i,
  input rv_exec_pkg::exec_out_t out_data_o
);

  int fail_count = 0;

  // ****************************************
  // Reset and output handshake
  // ****************************************
  out_idle_after_reset: assert property (@(posedge clk) rst |=> !out_valid_o)
    else begin
      $error("out_valid_o high in the cycle after reset");
      fail_count++;
    end

  out_held_while_stalled: assert property (@(posedge clk) disable iff (rst)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else begin
      $error("output changed while stalled");
      fail_count++;
    end

  // Driver side of the input handshake
  in_held_while_stalled: assert property (@(posedge clk) disable iff (rst)
      in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_data_i))
    else begin
      $error("input changed while stalled");
      fail_count++;
    end

endmodule

bind rv_exec_top rv_exec_props u_props (
  .clk         (clk),
  .rst         (rst),
  .in_valid_i  (in_valid_i),
  .in_ready_o  (in_ready_o),
  .in_data_i   (in_data_i),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .out_data_o  (out_data_o)
);

// File: tests/rv_exec_tb.sv
module rv_exec_tb;
  import rv_exec_pkg::*;

  logic      clk;
  logic      rst;
  logic      in_valid_i;
  logic      in_ready_o;
  exec_in_t  in_data_i;
  logic      out_valid_o;
  logic      out_ready_i;
  exec_out_t out_data_o;

  exec_in_t  vec_in[$];
  exec_out_t vec_exp[$];
  int        vec_id[$];
  exec_out_t exp_q[$];
  int        id_q[$];

  integer seed;
  int     errors;
  int     passed;

  rv_exec_top i_rv_exec_top (
    .clk         (clk),
    .rst         (rst),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .in_data_i   (in_data_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .out_data_o  (out_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // Output back-pressure, ready about three cycles in four
  initial begin
    seed = 32'h67b8_060f;
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk);
      out_ready_i <= (($random(seed) & 3) != 0);
    end
  end

  task automatic load_vectors();
    int              fd;
    int              n;
    int              f_id;
    string           line;
    logic [31:0]     f_instr;
    logic [31:0]     f_pc;
    logic [31:0]     f_rs1;
    logic [31:0]     f_rs2;
    logic [4:0]      f_rd;
    logic            f_wbe;
    logic [31:0]     f_wbd;
    logic [31:0]     f_npc;
    logic            f_eb;
    exec_in_t        vin;
    exec_out_t       vexp;
    fd = $fopen("tests/exec_input.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tests/exec_input.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%d %h %h %h %h %h %h %h %h %h", f_id, f_instr, f_pc,
                  f_rs1, f_rs2, f_rd, f_wbe, f_wbd, f_npc, f_eb);
      // Comment and blank lines do not scan
      if (n == 10) begin
        vin.instr     = f_instr;
        vin.pc        = f_pc;
        vin.rs1_val   = f_rs1;
        vin.rs2_val   = f_rs2;
        vexp.rd       = f_rd;
        vexp.wb_en    = f_wbe;
        vexp.wb_data  = f_wbd;
        vexp.next_pc  = f_npc;
        vexp.ebreak   = f_eb;
        vec_in.push_back(vin);
        vec_exp.push_back(vexp);
        vec_id.push_back(f_id);
      end
    end
    $fclose(fd);
  endtask

  task automatic send_vector(input int idx, output bit ok);
    int waited;
    in_valid_i <= 1'b1;
    in_data_i  <= vec_in[idx];
    waited = 0;
    @(posedge clk);
    while (!in_ready_o && waited < 200) begin
      waited++;
      @(posedge clk);
    end
    ok = in_ready_o;
    if (ok) begin
      exp_q.push_back(vec_exp[idx]);
      id_q.push_back(vec_id[idx]);
    end
  endtask

  task automatic drive_all();
    bit ok;
    foreach (vec_in[i]) begin
      send_vector(i, ok);
      if (!ok) begin
        $display("Timeout: the DUT did not accept test %0d within 200 cycles", vec_id[i]);
        errors++;
        break;
      end
    end
    in_valid_i <= 1'b0;
  endtask

  task automatic check_result(output bit ok);
    int        waited;
    int        id;
    bit        good;
    exec_out_t want;
    waited = 0;
    @(posedge clk);
    while (!(out_valid_o && out_ready_i) && waited < 200) begin
      waited++;
      @(posedge clk);
    end
    ok = out_valid_o && out_ready_i;
    if (!ok) begin
      return;
    end
    if (exp_q.size() == 0) begin
      $display("A result came out with no instruction outstanding");
      errors++;
      return;
    end
    want = exp_q.pop_front();
    id   = id_q.pop_front();
    good = 1'b1;
    if (out_data_o.next_pc !== want.next_pc) begin
      $display("[ERROR] %0t: test %0d next_pc %h, expected %h", $time, id,
               out_data_o.next_pc, want.next_pc);
      good = 1'b0;
    end
    if (out_data_o.wb_en !== want.wb_en) begin
      $display("[ERROR] %0t: test %0d wb_en %b, expected %b", $time, id,
               out_data_o.wb_en, want.wb_en);
      good = 1'b0;
    end
    if (out_data_o.ebreak !== want.ebreak) begin
      $display("[ERROR] %0t: test %0d ebreak %b, expected %b", $time, id,
               out_data_o.ebreak, want.ebreak);
      good = 1'b0;
    end
    // rd and wb_data only matter when the result is written
    if (want.wb_en && out_data_o.rd !== want.rd) begin
      $display("[ERROR] %0t: test %0d rd %0d, expected %0d", $time, id,
               out_data_o.rd, want.rd);
      good = 1'b0;
    end
    if (want.wb_en && out_data_o.wb_data !== want.wb_data) begin
      $display("[ERROR] %0t: test %0d wb_data %h, expected %h", $time, id,
               out_data_o.wb_data, want.wb_data);
      good = 1'b0;
    end
    if (good) begin
      passed++;
      $display("test %0d passed", id);
    end else begin
      errors++;
      $display("test %0d failed", id);
    end
  endtask

  task automatic check_all();
    bit ok;
    for (int i = 0; i < vec_in.size(); i++) begin
      check_result(ok);
      if (!ok) begin
        $display("Timeout: no result for test %0d within 200 cycles", vec_id[i]);
        errors++;
        break;
      end
    end
  endtask

  initial begin
    errors     = 0;
    passed     = 0;
    rst        = 1'b1;
    in_valid_i = 1'b0;
    in_data_i  = '0;
    load_vectors();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    fork
      drive_all();
      check_all();
    join
    errors += i_rv_exec_top.u_props.fail_count;
    $display("Summary: %0d tests, %0d passed, %0d errors", vec_in.size(), passed, errors);
    if (errors == 0 && vec_in.size() > 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/rv_exec_pkg.sv
verilog/rv_pipe_reg.sv
verilog/rv_decode.sv
verilog/rv_alu.sv
verilog/rv_csr_file.sv
verilog/rv_exec_stage.sv
verilog/rv_exec_top.sv
tests/rv_exec_properties.sv
tests/rv_exec_tb.sv

// File: verilog/rv_alu.sv
module rv_alu (
  input  logic [rv_exec_pkg::XLEN-1:0] a_i,
  input  logic [rv_exec_pkg::XLEN-1:0] b_i,
  input  rv_exec_pkg::alu_op_e         op_i,
  output logic [rv_exec_pkg::XLEN-1:0] res_o
);
  import rv_exec_pkg::*;

  logic [4:0] shamt;

  assign shamt = b_i[4:0];

  always_comb begin
    case (op_i)
      ADD:     res_o = a_i + b_i;
      SUB:     res_o = a_i - b_i;
      SLL:     res_o = a_i << shamt;
      SLT:     res_o = {{(XLEN-1){1'b0}}, $signed(a_i) < $signed(b_i)};
      SLTU:    res_o = {{(XLEN-1){1'b0}}, a_i < b_i};
      XOR:     res_o = a_i ^ b_i;
      SRL:     res_o = a_i >> shamt;
      // Sign fill from bit 31
      SRA:     res_o = $signed(a_i) >>> shamt;
      OR:      res_o = a_i | b_i;
      AND:     res_o = a_i & b_i;
      PASSB:   res_o = b_i;
      default: res_o = '0;
    endcase
  end

endmodule

// File: verilog/rv_csr_file.sv
module rv_csr_file (
  input  logic                         clk,
  input  logic                         rst,
  input  logic [11:0]                  raddr_i,
  output logic [rv_exec_pkg::XLEN-1:0] rdata_o,
  input  logic                         we_i,
  input  logic [11:0]                  waddr_i,
  input  logic [rv_exec_pkg::XLEN-1:0] wdata_i,
  input  logic                         trap_i,
  input  logic [rv_exec_pkg::XLEN-1:0] trap_pc_i,
  input  logic                         mret_i,
  output logic [rv_exec_pkg::XLEN-1:0] mtvec_o,
  output logic [rv_exec_pkg::XLEN-1:0] mepc_o
);
  import rv_exec_pkg::*;

  logic [XLEN-1:0] mstatus;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mcause;

  always_comb begin
    case (raddr_i)
      CSR_MSTATUS: rdata_o = mstatus;
      CSR_MTVEC:   rdata_o = mtvec;
      CSR_MEPC:    rdata_o = mepc;
      CSR_MCAUSE:  rdata_o = mcause;
      default:     rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      mstatus <= CSR_RST;
      mtvec   <= MTVEC_RST;
      mepc    <= CSR_RST;
      mcause  <= CSR_RST;
    end else if (trap_i) begin
      // Trap entry saves the interrupt enable
      mepc                  <= trap_pc_i;
      mcause                <= MCAUSE_ECALL_M;
      mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
      mstatus[MSTATUS_MIE]  <= 1'b0;
    end else if (mret_i) begin
      mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
      mstatus[MSTATUS_MPIE] <= 1'b1;
    end else if (we_i) begin
      case (waddr_i)
        CSR_MSTATUS: mstatus <= wdata_i;
        CSR_MTVEC:   mtvec   <= wdata_i;
        CSR_MEPC:    mepc    <= wdata_i;
        CSR_MCAUSE:  mcause  <= wdata_i;
        default: ;
      endcase
    end
  end

  assign mtvec_o = mtvec;
  assign mepc_o  = mepc;

endmodule

// File: verilog/rv_decode.sv
module rv_decode (
  input  rv_exec_pkg::exec_in_t in_i,
  output rv_exec_pkg::dec_t     dec_o
);
  import rv_exec_pkg::*;

  logic [XLEN-1:0] instr;
  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic            alt;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_j;
  logic            wb;

  function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt_bit,
                                              input logic is_reg);
    alu_op_e op;
    case (f3)
      F3_ADD:  op = (is_reg && alt_bit) ? SUB : ADD;
      F3_SLL:  op = SLL;
      F3_SLT:  op = SLT;
      F3_SLTU: op = SLTU;
      F3_XOR:  op = XOR;
      F3_SRL:  op = alt_bit ? SRA : SRL;
      F3_OR:   op = OR;
      F3_AND:  op = AND;
      default: op = ADD;
    endcase
    return op;
  endfunction

  assign instr  = in_i.instr;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign alt    = instr[30];
  assign rd     = instr[11:7];

  // ****************************************
  // Immediates
  // ****************************************
  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    dec_o               = '0;
    dec_o.pc            = in_i.pc;
    dec_o.op_a          = in_i.rs1_val;
    dec_o.op_b          = in_i.rs2_val;
    dec_o.imm           = imm_i;
    dec_o.alu_op        = ADD;
    dec_o.sys_op        = NONE;
    dec_o.branch_funct3 = funct3;
    dec_o.csr_addr      = instr[31:20];
    // Immediate CSR forms take the zero-extended rs1 field
    dec_o.csr_src       = funct3[2] ? {{(XLEN-5){1'b0}}, instr[19:15]} : in_i.rs1_val;
    dec_o.rd            = rd;
    wb                  = 1'b0;
    case (opcode)
      OP_LUI: begin
        dec_o.op_b   = imm_u;
        dec_o.alu_op = PASSB;
        wb           = 1'b1;
      end
      OP_AUIPC: begin
        dec_o.op_a = in_i.pc;
        dec_o.op_b = imm_u;
        wb         = 1'b1;
      end
      OP_JAL: begin
        dec_o.op_a    = in_i.pc;
        dec_o.op_b    = imm_j;
        dec_o.imm     = imm_j;
        dec_o.is_jump = 1'b1;
        wb            = 1'b1;
      end
      OP_JALR: begin
        dec_o.op_b    = imm_i;
        dec_o.is_jump = 1'b1;
        wb            = 1'b1;
      end
      OP_BRANCH: begin
        dec_o.imm       = imm_b;
        dec_o.is_branch = 1'b1;
        case (funct3)
          F3_BEQ, F3_BNE:   dec_o.alu_op = SUB;
          F3_BLT, F3_BGE:   dec_o.alu_op = SLT;
          F3_BLTU, F3_BGEU: dec_o.alu_op = SLTU;
          default:          dec_o.alu_op = SUB;
        endcase
      end
      OP_IMM: begin
        dec_o.op_b   = imm_i;
        dec_o.alu_op = alu_from_funct3(funct3, alt, 1'b0);
        wb           = 1'b1;
      end
      OP_REG: begin
        dec_o.alu_op = alu_from_funct3(funct3, alt, 1'b1);
        wb           = 1'b1;
      end
      OP_SYSTEM: begin
        case (funct3)
          F3_PRIV: begin
            case (instr[31:20])
              F12_ECALL:  dec_o.sys_op = ECALL;
              F12_EBREAK: dec_o.sys_op = EBREAK;
              F12_MRET:   dec_o.sys_op = MRET;
              default:    dec_o.sys_op = NONE;
            endcase
          end
          F3_CSRRW, F3_CSRRWI: begin
            dec_o.sys_op = CSRRW;
            wb           = 1'b1;
          end
          F3_CSRRS, F3_CSRRSI: begin
            dec_o.sys_op = CSRRS;
            wb           = 1'b1;
          end
          F3_CSRRC, F3_CSRRCI: begin
            dec_o.sys_op = CSRRC;
            wb           = 1'b1;
          end
          default: dec_o.sys_op = NONE;
        endcase
      end
      default: wb = 1'b0;
    endcase
    dec_o.wb_en = wb && (rd != 5'd0);
  end

endmodule

// File: verilog/rv_exec_pkg.sv
package rv_exec_pkg;

  localparam int XLEN = 32;

  // ****************************************
  // Opcodes and function fields
  // ****************************************
  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  localparam logic [2:0] F3_ADD  = 3'b000;
  localparam logic [2:0] F3_SLL  = 3'b001;
  localparam logic [2:0] F3_SLT  = 3'b010;
  localparam logic [2:0] F3_SLTU = 3'b011;
  localparam logic [2:0] F3_XOR  = 3'b100;
  localparam logic [2:0] F3_SRL  = 3'b101;
  localparam logic [2:0] F3_OR   = 3'b110;
  localparam logic [2:0] F3_AND  = 3'b111;

  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // funct3 of 000 under SYSTEM selects by the funct12 field
  localparam logic [2:0] F3_PRIV   = 3'b000;
  localparam logic [2:0] F3_CSRRW  = 3'b001;
  localparam logic [2:0] F3_CSRRS  = 3'b010;
  localparam logic [2:0] F3_CSRRC  = 3'b011;
  localparam logic [2:0] F3_CSRRWI = 3'b101;
  localparam logic [2:0] F3_CSRRSI = 3'b110;
  localparam logic [2:0] F3_CSRRCI = 3'b111;

  localparam logic [11:0] F12_ECALL  = 12'h000;
  localparam logic [11:0] F12_EBREAK = 12'h001;
  localparam logic [11:0] F12_MRET   = 12'h302;

  // ****************************************
  // Machine CSRs
  // ****************************************
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam int MSTATUS_MIE  = 3;
  localparam int MSTATUS_MPIE = 7;

  localparam logic [XLEN-1:0] MCAUSE_ECALL_M = 32'd11;
  localparam logic [XLEN-1:0] CSR_RST        = '0;
  localparam logic [XLEN-1:0] MTVEC_RST      = 32'h0000_0000;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, PASSB
  } alu_op_e;

  typedef enum logic [2:0] {
    NONE, CSRRW, CSRRS, CSRRC, ECALL, MRET, EBREAK
  } sys_op_e;

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;
  } exec_in_t;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] imm;
    alu_op_e         alu_op;
    logic            is_jump;
    logic            is_branch;
    logic [2:0]      branch_funct3;
    sys_op_e         sys_op;
    logic [11:0]     csr_addr;
    logic [XLEN-1:0] csr_src;
    logic [4:0]      rd;
    logic            wb_en;
  } dec_t;

  typedef struct packed {
    logic [4:0]      rd;
    logic            wb_en;
    logic [XLEN-1:0] wb_data;
    logic [XLEN-1:0] next_pc;
    logic            ebreak;
  } exec_out_t;

endpackage

// File: verilog/rv_exec_stage.sv
module rv_exec_stage (
  input  rv_exec_pkg::dec_t            dec_i,
  input  logic [rv_exec_pkg::XLEN-1:0] csr_rdata_i,
  input  logic [rv_exec_pkg::XLEN-1:0] mtvec_i,
  input  logic [rv_exec_pkg::XLEN-1:0] mepc_i,
  output rv_exec_pkg::exec_out_t       out_o,
  output logic [11:0]                  csr_raddr_o,
  output logic                         csr_we_o,
  output logic [11:0]                  csr_waddr_o,
  output logic [rv_exec_pkg::XLEN-1:0] csr_wdata_o,
  output logic                         trap_o,
  output logic [rv_exec_pkg::XLEN-1:0] trap_pc_o,
  output logic                         mret_o
);
  import rv_exec_pkg::*;

  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] pc_plus4;
  logic [XLEN-1:0] branch_target;
  logic [XLEN-1:0] jump_target;
  logic            res_zero;
  logic            take_branch;
  logic            is_csr;

  rv_alu u_alu (
    .a_i   (dec_i.op_a),
    .b_i   (dec_i.op_b),
    .op_i  (dec_i.alu_op),
    .res_o (alu_res)
  );

  assign pc_plus4      = dec_i.pc + XLEN'(4);
  assign branch_target = dec_i.pc + dec_i.imm;
  // JAL targets are already even, so clearing bit 0 only matters for JALR
  assign jump_target   = {alu_res[XLEN-1:1], 1'b0};
  assign res_zero      = (alu_res == '0);

  // ****************************************
  // Branch condition
  // ****************************************
  always_comb begin
    case (dec_i.branch_funct3)
      F3_BEQ:           take_branch = res_zero;
      F3_BNE:           take_branch = !res_zero;
      F3_BLT, F3_BLTU:  take_branch = !res_zero;
      F3_BGE, F3_BGEU:  take_branch = res_zero;
      default:          take_branch = 1'b0;
    endcase
  end

  // ****************************************
  // CSR read-modify-write
  // ****************************************
  assign is_csr      = dec_i.sys_op inside {CSRRW, CSRRS, CSRRC};
  assign csr_raddr_o = dec_i.csr_addr;
  assign csr_waddr_o = dec_i.csr_addr;
  assign csr_we_o    = is_csr;

  always_comb begin
    case (dec_i.sys_op)
      CSRRW:   csr_wdata_o = dec_i.csr_src;
      CSRRS:   csr_wdata_o = csr_rdata_i | dec_i.csr_src;
      CSRRC:   csr_wdata_o = csr_rdata_i & ~dec_i.csr_src;
      default: csr_wdata_o = csr_rdata_i;
    endcase
  end

  assign trap_o    = (dec_i.sys_op == ECALL);
  assign trap_pc_o = dec_i.pc;
  assign mret_o    = (dec_i.sys_op == MRET);

  // Writeback record and next pc
  always_comb begin
    out_o.rd      = dec_i.rd;
    out_o.wb_en   = dec_i.wb_en;
    out_o.ebreak  = (dec_i.sys_op == EBREAK);
    out_o.wb_data = alu_res;
    out_o.next_pc = pc_plus4;
    if (dec_i.is_jump) begin
      out_o.wb_data = pc_plus4;
      out_o.next_pc = jump_target;
    end else if (dec_i.is_branch) begin
      if (take_branch) begin
        out_o.next_pc = branch_target;
      end
    end else if (is_csr) begin
      // Old CSR value goes to rd
      out_o.wb_data = csr_rdata_i;
    end else if (trap_o) begin
      out_o.next_pc = mtvec_i;
    end else if (mret_o) begin
      out_o.next_pc = mepc_i;
    end
  end

endmodule

// File: verilog/rv_exec_top.sv
module rv_exec_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   in_valid_i,
  output logic                   in_ready_o,
  input  rv_exec_pkg::exec_in_t  in_data_i,
  output logic                   out_valid_o,
  input  logic                   out_ready_i,
  output rv_exec_pkg::exec_out_t out_data_o
);
  import rv_exec_pkg::*;

  dec_t            dec_d;
  dec_t            dec_q;
  logic            dec_valid;
  logic            dec_ready;
  exec_out_t       exec_d;
  logic            commit;
  logic [11:0]     csr_raddr;
  logic [XLEN-1:0] csr_rdata;
  logic            csr_we;
  logic [11:0]     csr_waddr;
  logic [XLEN-1:0] csr_wdata;
  logic            trap;
  logic [XLEN-1:0] trap_pc;
  logic            mret;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;

  rv_decode u_decode (
    .in_i  (in_data_i),
    .dec_o (dec_d)
  );

  rv_pipe_reg #(.payload_t(dec_t)) u_dec_reg (
    .clk     (clk),
    .rst     (rst),
    .valid_i (in_valid_i),
    .ready_o (in_ready_o),
    .data_i  (dec_d),
    .valid_o (dec_valid),
    .ready_i (dec_ready),
    .data_o  (dec_q)
  );

  rv_exec_stage u_exec (
    .dec_i       (dec_q),
    .csr_rdata_i (csr_rdata),
    .mtvec_i     (mtvec),
    .mepc_i      (mepc),
    .out_o       (exec_d),
    .csr_raddr_o (csr_raddr),
    .csr_we_o    (csr_we),
    .csr_waddr_o (csr_waddr),
    .csr_wdata_o (csr_wdata),
    .trap_o      (trap),
    .trap_pc_o   (trap_pc),
    .mret_o      (mret)
  );

  rv_pipe_reg #(.payload_t(exec_out_t)) u_out_reg (
    .clk     (clk),
    .rst     (rst),
    .valid_i (dec_valid),
    .ready_o (dec_ready),
    .data_i  (exec_d),
    .valid_o (out_valid_o),
    .ready_i (out_ready_i),
    .data_o  (out_data_o)
  );

  // CSR side effects land only when the result moves into u_out_reg
  assign commit = dec_valid & dec_ready;

  rv_csr_file u_csr (
    .clk       (clk),
    .rst       (rst),
    .raddr_i   (csr_raddr),
    .rdata_o   (csr_rdata),
    .we_i      (csr_we & commit),
    .waddr_i   (csr_waddr),
    .wdata_i   (csr_wdata),
    .trap_i    (trap & commit),
    .trap_pc_i (trap_pc),
    .mret_i    (mret & commit),
    .mtvec_o   (mtvec),
    .mepc_o    (mepc)
  );

endmodule

// File: verilog/rv_pipe_reg.sv
module rv_pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     valid_i,
  output logic     ready_o,
  input  payload_t data_i,
  output logic     valid_o,
  input  logic     ready_i,
  output payload_t data_o
);

  logic     full;
  payload_t data_q;

  // Accept when empty or when the current entry leaves this cycle
  assign ready_o = !full || ready_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      full <= 1'b0;
    end else if (ready_o) begin
      full <= valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  assign valid_o = full;
  assign data_o  = data_q;

endmodule
